//--- friscMem.f
+incdir+verilog
verilog/friscPkg.sv
verilog/syncRam.sv
verilog/busMaster.sv
verilog/dataCache.sv
verilog/memRouter.sv
verilog/friscMem.sv
sim/busModel.sv
sim/tbFriscMem.sv

//--- Bender.yml
package:
  name: friscMem

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/friscPkg.sv
      - verilog/syncRam.sv
      - verilog/busMaster.sv
      - verilog/dataCache.sv
      - verilog/memRouter.sv
      - verilog/friscMem.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - sim/busModel.sv
      - sim/tbFriscMem.sv

//--- sim/tbFriscMem.sv
`timescale 1ns/1ps
`include "frisc_macros.svh"

module tbFriscMem;

  localparam int NumOps  = 210;
  localparam int OpLimit = 40; // cycles one operation may take
  localparam logic [`ADDR_W-1:0] DwBase = 32'h0000_0400;
  localparam logic [`ADDR_W-1:0] DwTop  = 32'h0000_0800;
  localparam logic [`DATA_W-1:0] FillPattern = 32'hA5A5_0000;

  logic               SYSCLK;
  logic               rstN;
  logic               cpuRd;
  logic               cpuWr;
  logic [`ADDR_W-1:0] cpuAddr;
  logic [`DATA_W-1:0] cpuWrData;
  logic [`DATA_W-1:0] cpuRdData;
  logic               cpuRdValid;
  logic               cpuBusy;
  logic [`ADDR_W-1:0] cfgDwBase;
  logic [`ADDR_W-1:0] cfgDwTop;
  logic               lReq;
  logic               lWrite;
  logic               lTrdy;
  logic [`ADDR_W-1:0] lAddr;
  logic [`DATA_W-1:0] lDataO;
  logic [`DATA_W-1:0] lDataI;

  // shadow copies for the reference model
  logic [`DATA_W-1:0] dwShadow [256];
  logic               dwWritten [256];
  logic [`DATA_W-1:0] extShadow [4096];
  logic               extWritten [4096];
  logic [`DATA_W-1:0] expQ [$];

  int          errors;
  int          checks;
  int          testsRun;
  int          testsFailed;
  int          busReads;
  int          busWrites;
  int          reqCycles;
  logic [31:0] lastWrAddr;
  logic [31:0] lastWrData;
  logic [31:0] rngState;

  friscMem u_friscMem (
    .SYSCLK     (SYSCLK),
    .rstN       (rstN),
    .cpuRd      (cpuRd),
    .cpuWr      (cpuWr),
    .cpuAddr    (cpuAddr),
    .cpuWrData  (cpuWrData),
    .cpuRdData  (cpuRdData),
    .cpuRdValid (cpuRdValid),
    .cpuBusy    (cpuBusy),
    .cfgDwBase  (cfgDwBase),
    .cfgDwTop   (cfgDwTop),
    .lReq       (lReq),
    .lWrite     (lWrite),
    .lAddr      (lAddr),
    .lDataO     (lDataO),
    .lDataI     (lDataI),
    .lTrdy      (lTrdy)
  );

  busModel u_busModel (
    .SYSCLK (SYSCLK),
    .rstN   (rstN),
    .lReq   (lReq),
    .lWrite (lWrite),
    .lAddr  (lAddr),
    .lDataO (lDataO),
    .lDataI (lDataI),
    .lTrdy  (lTrdy)
  );

  initial begin
    SYSCLK = 1'b0;
    forever #2 SYSCLK = ~SYSCLK;
  end

  initial begin
    repeat (NumOps * OpLimit + 500) @(posedge SYSCLK);
    $display("watchdog expired after %0d cycles, the DUT hung", NumOps * OpLimit + 500);
    $display("STATUS: FAIL");
    $finish;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic inWindow(input logic [`ADDR_W-1:0] a);
    return (a >= DwBase) && (a < DwTop);
  endfunction

  // reference model for every load
  function automatic logic [`DATA_W-1:0] expectedRead(input logic [`ADDR_W-1:0] a);
    if (inWindow(a)) begin
      return dwShadow[a[9:2]];
    end
    if (extWritten[a[13:2]]) begin
      return extShadow[a[13:2]];
    end
    return {a[`ADDR_W-1:2], 2'b00} ^ FillPattern;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
    end
  endtask

  task automatic nextCycle();
    @(posedge SYSCLK);
    #1;
  endtask

  task automatic waitIdle();
    int waited;
    waited = 0;
    while (cpuBusy && waited < OpLimit) begin
      nextCycle();
      waited++;
    end
    if (cpuBusy) begin
      errors++;
      $display("cpuBusy stuck high for %0d cycles at %0t", OpLimit, $time);
    end
  endtask

  task automatic readOp(input logic [`ADDR_W-1:0] a, output int latency);
    int waited;
    waitIdle();
    expQ.push_back(expectedRead(a));
    cpuRd   = 1'b1;
    cpuAddr = a;
    nextCycle();
    cpuRd  = 1'b0;
    waited = 1;
    while (!cpuRdValid && waited < OpLimit) begin
      nextCycle();
      waited++;
    end
    if (!cpuRdValid) begin
      errors++;
      $display("read of %h never returned data, gave up at %0t", a, $time);
      expQ.delete();
    end
    latency = waited;
    nextCycle(); // lets the compare process see the data
  endtask

  task automatic writeOp(input logic [`ADDR_W-1:0] a, input logic [`DATA_W-1:0] d);
    int wrBefore;
    waitIdle();
    wrBefore  = busWrites;
    cpuWr     = 1'b1;
    cpuAddr   = a;
    cpuWrData = d;
    nextCycle();
    cpuWr = 1'b0;
    waitIdle();
    if (inWindow(a)) begin
      dwShadow[a[9:2]]  = d;
      dwWritten[a[9:2]] = 1'b1;
      check("busWrites", busWrites, wrBefore);
    end else begin
      extShadow[a[13:2]]  = d; // write-through, no allocate
      extWritten[a[13:2]] = 1'b1;
      check("busWrites", busWrites, wrBefore + 1);
      check("lAddr", lastWrAddr, a);
      check("lDataO", lastWrData, d);
    end
  endtask

  task automatic reportTest(input string name, input int errBefore);
    testsRun++;
    if (errors == errBefore) begin
      $display("test %0d %s: ok", testsRun, name);
    end else begin
      testsFailed++;
      $display("test %0d %s: failed with %0d errors", testsRun, name, errors - errBefore);
    end
  endtask

  // compares every returned load against the queued prediction
  always @(negedge SYSCLK) begin
    if (rstN && cpuRdValid) begin
      if (expQ.size() == 0) begin
        errors++;
        $display("cpuRdValid pulsed at %0t with no load outstanding", $time);
      end else begin
        check("cpuRdData", cpuRdData, expQ.pop_front());
      end
    end
  end

  always @(negedge SYSCLK) begin
    if (rstN && lReq) begin
      reqCycles++;
      if (lTrdy && lWrite) begin
        busWrites++;
        lastWrAddr = lAddr;
        lastWrData = lDataO;
      end else if (lTrdy) begin
        busReads++;
      end
    end
  end

  initial begin
    int          lat;
    int          base;
    int          reads;
    int          reqs;
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] d;
    rstN        = 1'b0;
    cpuRd       = 1'b0;
    cpuWr       = 1'b0;
    cpuAddr     = '0;
    cpuWrData   = '0;
    cfgDwBase   = DwBase;
    cfgDwTop    = DwTop;
    errors      = 0;
    checks      = 0;
    testsRun    = 0;
    testsFailed = 0;
    busReads    = 0;
    busWrites   = 0;
    reqCycles   = 0;
    rngState    = 32'd12;
    for (int i = 0; i < 256; i++) begin
      dwWritten[i] = 1'b0;
    end
    for (int i = 0; i < 4096; i++) begin
      extWritten[i] = 1'b0;
    end
    repeat (5) @(posedge SYSCLK);
    #1;
    rstN = 1'b1;

    base = errors;
    check("cpuBusy", cpuBusy, 0);
    check("cpuRdValid", cpuRdValid, 0);
    check("lReq", lReq, 0);
    reportTest("reset state", base);

    base = errors;
    reqs = reqCycles;
    writeOp(32'h0000_0410, 32'h1234_5678);
    readOp(32'h0000_0410, lat);
    check("local read latency", lat, 1);
    check("lReq cycles", reqCycles, reqs);
    reportTest("local RAM", base);

    base  = errors;
    reads = busReads;
    readOp(32'h0000_0100, lat);
    check("busReads", busReads, reads + 1);
    reqs = reqCycles;
    readOp(32'h0000_0100, lat);
    check("hit latency", lat, 1);
    check("lReq cycles", reqCycles, reqs);
    reportTest("read miss then hit", base);

    base = errors;
    writeOp(32'h0000_0100, 32'hDEAD_BEEF);
    reads = busReads;
    readOp(32'h0000_0100, lat);
    check("busReads", busReads, reads);
    check("hit latency", lat, 1);
    reportTest("write-through hit", base);

    // same index 2, different tags
    base = errors;
    readOp(32'h0000_0108, lat);
    readOp(32'h0000_1108, lat);
    reads = busReads;
    readOp(32'h0000_0108, lat);
    check("busReads", busReads, reads + 1);
    readOp(32'h0000_1108, lat);
    check("busReads", busReads, reads + 2);
    reportTest("eviction", base);

    base = errors;
    for (int n = 0; n < 200; n++) begin
      rngState = xorshift32(rngState);
      r        = rngState;
      if (r[2:1] == 2'd0) begin
        a = DwBase + {r[7:4], 2'b00}; // 16 local words
      end else begin
        a = {r[9:8], 12'h000} + {r[10], 6'b0} + {r[12:11], 2'b00}; // 8 tags per index
      end
      rngState = xorshift32(rngState);
      d        = rngState;
      if (r[0] || (inWindow(a) && !dwWritten[a[9:2]])) begin
        writeOp(a, d);
      end else begin
        readOp(a, lat);
      end
    end
    reportTest("random loads and stores", base);

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             testsRun, testsFailed, checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- sim/busModel.sv
`timescale 1ns/1ps
`include "frisc_macros.svh"

module busModel (
  input  logic               SYSCLK,
  input  logic               rstN,
  input  logic               lReq,
  input  logic               lWrite,
  input  logic [`ADDR_W-1:0] lAddr,
  input  logic [`DATA_W-1:0] lDataO,
  output logic [`DATA_W-1:0] lDataI,
  output logic               lTrdy
);

  localparam int MemWords = 4096; // byte addresses below 0x4000
  localparam logic [`DATA_W-1:0] FillPattern = 32'hA5A5_0000;

  logic [`DATA_W-1:0] memData [MemWords];
  logic               memWritten [MemWords];
  logic               trdyQ = 1'b0;
  logic [`DATA_W-1:0] dataQ = '0;
  logic               armed;
  logic [1:0]         waitCnt;
  logic [1:0]         waitNow;
  logic [31:0]        rngState = 32'd12;
  logic [11:0]        wordIdx;

  assign wordIdx = lAddr[13:2];
  assign lTrdy   = trdyQ;
  assign lDataI  = dataQ;

  // a fresh request draws its wait, later cycles count it down
  assign waitNow = armed ? waitCnt : rngState[1:0];

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // words never written read back as their own address xor a pattern
  function automatic logic [`DATA_W-1:0] readWord(input logic [`ADDR_W-1:0] a);
    if (memWritten[a[13:2]]) begin
      return memData[a[13:2]];
    end
    return {a[`ADDR_W-1:2], 2'b00} ^ FillPattern;
  endfunction

  always @(posedge SYSCLK) begin
    if (!rstN) begin
      trdyQ   <= 1'b0;
      armed   <= 1'b0;
      waitCnt <= '0;
      for (int i = 0; i < MemWords; i++) begin
        memWritten[i] <= 1'b0;
      end
    end else if (trdyQ && lReq) begin
      if (lWrite) begin // commit the write on the handshake
        memData[wordIdx]    <= lDataO;
        memWritten[wordIdx] <= 1'b1;
      end
      trdyQ <= 1'b0;
      armed <= 1'b0;
    end else if (lReq) begin
      armed <= 1'b1;
      if (!armed) begin
        rngState <= xorshift32(rngState);
      end
      if (waitNow == 2'd0) begin // lTrdy 1 to 4 cycles after lReq
        trdyQ <= 1'b1;
        dataQ <= readWord(lAddr);
      end else begin
        waitCnt <= waitNow - 2'd1;
      end
    end
  end

endmodule

//--- verilog/friscMem.sv
`timescale 1ns/1ps
`include "frisc_macros.svh"

module friscMem (
  input  logic               SYSCLK,
  input  logic               rstN,
  input  logic               cpuRd,
  input  logic               cpuWr,
  input  logic [`ADDR_W-1:0] cpuAddr,
  input  logic [`DATA_W-1:0] cpuWrData,
  output logic [`DATA_W-1:0] cpuRdData,
  output logic               cpuRdValid,
  output logic               cpuBusy,
  input  logic [`ADDR_W-1:0] cfgDwBase,
  input  logic [`ADDR_W-1:0] cfgDwTop,
  output logic               lReq,
  output logic               lWrite,
  output logic [`ADDR_W-1:0] lAddr,
  output logic [`DATA_W-1:0] lDataO,
  input  logic [`DATA_W-1:0] lDataI,
  input  logic               lTrdy
);

  import friscPkg::*;

  logic               cacheRd;
  logic               cacheWr;
  logic [`DATA_W-1:0] cacheRdData;
  logic               cacheRdValid;
  logic               cacheBusy;
  logic               busStart;
  busCmdE             busCmd;
  logic [`ADDR_W-1:0] busAddr;
  logic [`DATA_W-1:0] busWrData;
  logic               busDone;
  logic [`DATA_W-1:0] busRdData;

  memRouter u_memRouter (
    .SYSCLK       (SYSCLK),
    .rstN         (rstN),
    .cpuRd        (cpuRd),
    .cpuWr        (cpuWr),
    .cpuAddr      (cpuAddr),
    .cpuWrData    (cpuWrData),
    .cfgDwBase    (cfgDwBase),
    .cfgDwTop     (cfgDwTop),
    .cacheRdData  (cacheRdData),
    .cacheRdValid (cacheRdValid),
    .cacheBusy    (cacheBusy),
    .cpuRdData    (cpuRdData),
    .cpuRdValid   (cpuRdValid),
    .cpuBusy      (cpuBusy),
    .cacheRd      (cacheRd),
    .cacheWr      (cacheWr)
  );

  // address and write data go to the cache directly, strobes are steered
  dataCache u_dataCache (
    .SYSCLK       (SYSCLK),
    .rstN         (rstN),
    .cacheRd      (cacheRd),
    .cacheWr      (cacheWr),
    .addr         (cpuAddr),
    .wrData       (cpuWrData),
    .busDone      (busDone),
    .busRdData    (busRdData),
    .cacheRdData  (cacheRdData),
    .cacheRdValid (cacheRdValid),
    .cacheBusy    (cacheBusy),
    .busStart     (busStart),
    .busCmd       (busCmd),
    .busAddr      (busAddr),
    .busWrData    (busWrData)
  );

  busMaster u_busMaster (
    .SYSCLK    (SYSCLK),
    .rstN      (rstN),
    .busStart  (busStart),
    .busCmd    (busCmd),
    .busAddr   (busAddr),
    .busWrData (busWrData),
    .lTrdy     (lTrdy),
    .lDataI    (lDataI),
    .busDone   (busDone),
    .busRdData (busRdData),
    .lReq      (lReq),
    .lWrite    (lWrite),
    .lAddr     (lAddr),
    .lDataO    (lDataO)
  );

endmodule

//--- verilog/memRouter.sv
`timescale 1ns/1ps
`include "frisc_macros.svh"

module memRouter (
  input  logic               SYSCLK,
  input  logic               rstN,
  input  logic               cpuRd,
  input  logic               cpuWr,
  input  logic [`ADDR_W-1:0] cpuAddr,
  input  logic [`DATA_W-1:0] cpuWrData,
  input  logic [`ADDR_W-1:0] cfgDwBase,
  input  logic [`ADDR_W-1:0] cfgDwTop,
  input  logic [`DATA_W-1:0] cacheRdData,
  input  logic               cacheRdValid,
  input  logic               cacheBusy,
  output logic [`DATA_W-1:0] cpuRdData,
  output logic               cpuRdValid,
  output logic               cpuBusy,
  output logic               cacheRd,
  output logic               cacheWr
);

  logic               inDw;
  logic               dwCs;
  logic               dwRdQ;
  logic [`DATA_W-1:0] dwRdData;

  // base <= addr < top selects the local RAM
  assign inDw = (cpuAddr >= cfgDwBase) && (cpuAddr < cfgDwTop);
  assign dwCs = (cpuRd | cpuWr) & inDw;

  assign cacheRd = cpuRd & !inDw;
  assign cacheWr = cpuWr & !inDw;

  syncRam #(.depth(1 << `DW_ADDR_BITS), .width(`DATA_W)) u_dwRam (
    .clk    (SYSCLK),
    .cs     (dwCs),
    .we     (cpuWr),
    .addr   (cpuAddr[`DW_ADDR_BITS+1:2]),
    .wrData (cpuWrData),
    .rdData (dwRdData)
  );

  always_ff @(posedge SYSCLK) begin
    if (!rstN) begin
      dwRdQ <= 1'b0;
    end else begin
      dwRdQ <= cpuRd & inDw; // local data shows up next cycle
    end
  end

  assign cpuRdData  = dwRdQ ? dwRdData : cacheRdData;
  assign cpuRdValid = dwRdQ | cacheRdValid;
  assign cpuBusy    = cacheBusy; // local RAM never stalls

endmodule

//--- verilog/dataCache.sv
`timescale 1ns/1ps
`include "frisc_macros.svh"

module dataCache (
  input  logic               SYSCLK,
  input  logic               rstN,
  input  logic               cacheRd,
  input  logic               cacheWr,
  input  logic [`ADDR_W-1:0] addr,
  input  logic [`DATA_W-1:0] wrData,
  input  logic               busDone,
  input  logic [`DATA_W-1:0] busRdData,
  output logic [`DATA_W-1:0] cacheRdData,
  output logic               cacheRdValid,
  output logic               cacheBusy,
  output logic               busStart,
  output friscPkg::busCmdE   busCmd,
  output logic [`ADDR_W-1:0] busAddr,
  output logic [`DATA_W-1:0] busWrData
);

  import friscPkg::*;

  localparam int Lines = 1 << `DC_INDEX_BITS;
  localparam int TagW  = `DC_TAG_BITS + 1; // msb is the stored valid bit

  cacheStateE state;

  logic [`ADDR_W-1:0]        addrQ;
  logic [`DATA_W-1:0]        wrDataQ;
  logic                      isWrQ;
  logic [Lines-1:0]          validQ;
  logic [`DC_INDEX_BITS-1:0] idxIn;
  logic [`DC_INDEX_BITS-1:0] idxQ;
  logic [`DC_INDEX_BITS-1:0] ramIdx;
  logic [`DC_TAG_BITS-1:0]   tagQ;
  logic [TagW-1:0]           tagRd;
  logic [`DATA_W-1:0]        dataRd;
  logic [`DATA_W-1:0]        dataWrData;
  logic                      idle;
  logic                      strobe;
  logic                      lookup;
  logic                      hit;
  logic                      fillDone;
  logic                      wrHit;
  logic                      tagCs;
  logic                      dataCs;
  logic                      dataWe;

  assign idle   = (state == CS_IDLE);
  assign lookup = (state == CS_LOOKUP);
  assign strobe = cacheRd | cacheWr;
  assign idxIn  = addr[`DC_INDEX_BITS+1:2];
  assign idxQ   = addrQ[`DC_INDEX_BITS+1:2];
  assign tagQ   = addrQ[`ADDR_W-1:`DC_INDEX_BITS+2];
  assign ramIdx = idle ? idxIn : idxQ; // index the RAMs on the strobe cycle

  assign hit      = validQ[idxQ] & tagRd[`DC_TAG_BITS] & (tagRd[`DC_TAG_BITS-1:0] == tagQ);
  assign fillDone = (state == CS_FILL) & busDone;
  assign wrHit    = lookup & isWrQ & hit;

  assign tagCs      = (idle & strobe) | fillDone;
  assign dataCs     = tagCs | wrHit;
  assign dataWe     = fillDone | wrHit;
  assign dataWrData = fillDone ? busRdData : wrDataQ;

  syncRam #(.depth(Lines), .width(TagW)) u_tagRam (
    .clk    (SYSCLK),
    .cs     (tagCs),
    .we     (fillDone),
    .addr   (ramIdx),
    .wrData ({1'b1, tagQ}),
    .rdData (tagRd)
  );

  syncRam #(.depth(Lines), .width(`DATA_W)) u_dataRam (
    .clk    (SYSCLK),
    .cs     (dataCs),
    .we     (dataWe),
    .addr   (ramIdx),
    .wrData (dataWrData),
    .rdData (dataRd)
  );

  always_ff @(posedge SYSCLK) begin
    if (!rstN) begin
      state  <= CS_IDLE;
      validQ <= '0;
    end else begin
      case (state)
        CS_IDLE: begin
          if (strobe) begin
            state <= CS_LOOKUP;
          end
        end
        CS_LOOKUP: begin
          if (isWrQ) begin
            state <= CS_WRITE; // write-through, hit or not
          end else if (hit) begin
            state <= CS_IDLE;
          end else begin
            state <= CS_FILL;
          end
        end
        CS_FILL: begin
          if (busDone) begin
            state        <= CS_IDLE;
            validQ[idxQ] <= 1'b1;
          end
        end
        CS_WRITE: begin
          if (busDone) begin
            state <= CS_IDLE;
          end
        end
        default: state <= CS_IDLE;
      endcase
    end
  end

  always_ff @(posedge SYSCLK) begin
    if (idle && strobe) begin
      addrQ   <= addr;
      wrDataQ <= wrData;
      isWrQ   <= cacheWr;
    end
  end

  assign cacheBusy    = !idle;
  assign cacheRdValid = (lookup & !isWrQ & hit) | fillDone;
  assign cacheRdData  = (state == CS_FILL) ? busRdData : dataRd;

  // misses and all writes go out on the bus
  assign busStart  = lookup & (isWrQ | !hit);
  assign busCmd    = isWrQ ? CMD_WRITE : CMD_READ;
  assign busAddr   = addrQ;
  assign busWrData = wrDataQ;

endmodule

//--- verilog/busMaster.sv
`timescale 1ns/1ps
`include "frisc_macros.svh"

module busMaster (
  input  logic               SYSCLK,
  input  logic               rstN,
  input  logic               busStart,
  input  friscPkg::busCmdE   busCmd,
  input  logic [`ADDR_W-1:0] busAddr,
  input  logic [`DATA_W-1:0] busWrData,
  input  logic               lTrdy,
  input  logic [`DATA_W-1:0] lDataI,
  output logic               busDone,
  output logic [`DATA_W-1:0] busRdData,
  output logic               lReq,
  output logic               lWrite,
  output logic [`ADDR_W-1:0] lAddr,
  output logic [`DATA_W-1:0] lDataO
);

  import friscPkg::*;

  busStateE state;
  busCmdE   cmdQ;
  logic     xferDone;

  // transfer completes when the target answers while we request
  assign xferDone = (state == BS_WAIT) & lTrdy;

  always_ff @(posedge SYSCLK) begin
    if (!rstN) begin
      state   <= BS_IDLE;
      busDone <= 1'b0;
    end else begin
      busDone <= xferDone; // one cycle after the handshake
      case (state)
        BS_IDLE: begin
          if (busStart) begin
            state <= BS_WAIT;
          end
        end
        BS_WAIT: begin
          if (lTrdy) begin
            state <= BS_IDLE;
          end
        end
        default: state <= BS_IDLE;
      endcase
    end
  end

  // request payload stays put while lReq is high
  always_ff @(posedge SYSCLK) begin
    if ((state == BS_IDLE) && busStart) begin
      cmdQ   <= busCmd;
      lAddr  <= busAddr;
      lDataO <= busWrData;
    end
    if (xferDone) begin
      busRdData <= lDataI;
    end
  end

  assign lReq   = (state == BS_WAIT);
  assign lWrite = (cmdQ == CMD_WRITE);

endmodule

//--- verilog/syncRam.sv
`timescale 1ns/1ps

module syncRam #(
  parameter int depth = 16,
  parameter int width = 32
) (
  input  logic                     clk,
  input  logic                     cs,
  input  logic                     we,
  input  logic [$clog2(depth)-1:0] addr,
  input  logic [width-1:0]         wrData,
  output logic [width-1:0]         rdData
);

  logic [width-1:0] mem [depth];

  // single port, write has priority over read
  always_ff @(posedge clk) begin
    if (cs) begin
      if (we) begin
        mem[addr] <= wrData;
      end else begin
        rdData <= mem[addr]; // holds until the next read
      end
    end
  end

endmodule

//--- verilog/friscPkg.sv
package friscPkg;

  // data cache controller
  typedef enum logic [1:0] {
    CS_IDLE,
    CS_LOOKUP, // tag compare, data RAM output valid
    CS_FILL,   // waiting for the refill word
    CS_WRITE   // write-through in progress
  } cacheStateE;

  // external bus master
  typedef enum logic {
    BS_IDLE,
    BS_WAIT
  } busStateE;

  typedef enum logic {
    CMD_READ  = 1'b0,
    CMD_WRITE = 1'b1
  } busCmdE;

endpackage

//--- verilog/frisc_macros.svh
`ifndef FRISC_MACROS_SVH
`define FRISC_MACROS_SVH

// datapath widths
`define DATA_W 32
`define ADDR_W 32

// data cache geometry, one word per line
// index is addr[5:2], tag is addr[31:6]
`define DC_INDEX_BITS 4
`define DC_TAG_BITS   26

// local data RAM window, 256 words indexed by addr[9:2]
`define DW_ADDR_BITS 8

`endif
